// ==== bch_defines.svh ====
`ifndef BCH_DEFINES_SVH
`define BCH_DEFINES_SVH

// ***************************************************************************
// BCH(15,7) code over GF(16), double error correcting
// ***************************************************************************

// code length, message length, field width, correction capability
`define BCH_N 15
`define BCH_K 7
`define BCH_M 4
`define BCH_T 2

// g(x) = x^8 + x^7 + x^6 + x^4 + 1
`define BCH_GEN_POLY 9'o721

// field polynomial x^4 + x + 1
`define BCH_PRIM_POLY 5'b10011

// codewords the checker can hold between push and final pop
`define BCH_RING_DEPTH 4

`endif

// ==== bch_pkg.sv ====
`include "bch_defines.svh"

package bch_pkg;

	typedef logic [`BCH_M-1:0] gf_t;
	typedef logic [`BCH_N-1:0] codeword_t; // bit i is the i-th bit on the wire
	typedef logic [`BCH_K-1:0] message_t;
	typedef logic [$clog2(`BCH_T + 2)-1:0] err_count_t; // top value means uncorrectable

	typedef enum logic [1:0] {solver_idle, solver_cube, solver_divide, solver_hold} solver_state_e;
	typedef enum logic {chien_idle, chien_scan} chien_state_e;

	localparam gf_t gf_reduce = gf_t'(`BCH_PRIM_POLY); // x^4 folded back onto the low bits
	localparam gf_t gf_alpha = gf_t'(2);
	localparam gf_t gf_alpha2 = gf_t'(4);
	localparam gf_t gf_alpha3 = gf_t'(8);

	// shift and add multiply, reducing after every shift
	function automatic gf_t gf_mul(input gf_t a, input gf_t b);
		gf_t acc;
		gf_t x;
		acc = '0;
		x = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc = acc ^ x;
			x = x[`BCH_M-1] ? ((x << 1) ^ gf_reduce) : (x << 1);
		end
		return acc;
	endfunction

	// a^-1 = a^14 in GF(16), zero maps to zero
	function automatic gf_t gf_inv(input gf_t a);
		gf_t a2;
		gf_t a4;
		gf_t a8;
		a2 = gf_mul(a, a);
		a4 = gf_mul(a2, a2);
		a8 = gf_mul(a4, a4);
		return gf_mul(gf_mul(a2, a4), a8);
	endfunction

endpackage

// ==== bch_encoder.sv ====
`timescale 1ns/1ps

`include "bch_defines.svh"

module bch_encoder import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input message_t message,
	output logic out_bit,
	output logic out_first,
	output logic busy
);

	localparam int parity_bits = `BCH_N - `BCH_K;
	localparam logic [parity_bits-1:0] gen_taps = parity_bits'(`BCH_GEN_POLY); // x^8 is implied
	localparam logic [3:0] last_pos = 4'(`BCH_N - 1);

	message_t msg_sr;
	logic [parity_bits-1:0] lfsr;
	logic [3:0] pos;
	logic msg_phase;
	logic feedback;

	assign msg_phase = pos < `BCH_K;
	assign feedback = msg_sr[0] ^ lfsr[parity_bits-1];

	// systematic output, message first and then the remainder
	assign out_bit = msg_phase ? msg_sr[0] : lfsr[parity_bits-1];
	assign out_first = busy && (pos == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			pos <= '0;
		end else if (start && !busy) begin
			busy <= 1'b1;
			pos <= '0;
		end else if (busy) begin
			pos <= pos + 4'd1;
			if (pos == last_pos)
				busy <= 1'b0; // word complete after fifteen bits
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			msg_sr <= message;
			lfsr <= '0;
		end else if (busy) begin
			msg_sr <= msg_sr >> 1;
			if (msg_phase) begin
				// divide m(x) x^8 by g(x) as the message goes by
				lfsr <= {lfsr[parity_bits-2:0], 1'b0} ^ (feedback ? gen_taps : '0);
			end else begin
				lfsr <= lfsr << 1; // now just draining the parity
			end
		end
	end

endmodule

// ==== bch_syndrome.sv ====
`timescale 1ns/1ps

`include "bch_defines.svh"

module bch_syndrome import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic in_bit,
	output gf_t s1,
	output gf_t s3,
	output logic syn_done
);

	localparam logic [3:0] last_pos = 4'(`BCH_N - 1);

	logic active;
	logic [3:0] cnt;
	gf_t acc1;
	gf_t acc3;
	gf_t next1;
	gf_t next3;

	// Horner step, the first bit ends up on x^14
	assign next1 = gf_mul(acc1, gf_alpha) ^ gf_t'(in_bit);
	assign next3 = gf_mul(acc3, gf_alpha3) ^ gf_t'(in_bit);

	// ***************************************************************************
	// bit counter and done strobe
	// ***************************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt <= '0;
			syn_done <= 1'b0;
		end else begin
			syn_done <= 1'b0;
			if (start) begin
				active <= 1'b1; // bit 0 is already on in_bit
				cnt <= 4'd1;
			end else if (active) begin
				cnt <= cnt + 4'd1;
				if (cnt == last_pos) begin
					active <= 1'b0;
					syn_done <= 1'b1;
				end
			end
		end
	end

	// ***************************************************************************
	// accumulators
	// ***************************************************************************

	always_ff @(posedge clk) begin
		if (start) begin
			acc1 <= gf_t'(in_bit);
			acc3 <= gf_t'(in_bit);
		end else if (active) begin
			acc1 <= next1;
			acc3 <= next3;
			if (cnt == last_pos) begin
				s1 <= next1; // held until the next word finishes
				s3 <= next3;
			end
		end
	end

endmodule

// ==== bch_locator_solver.sv ====
`timescale 1ns/1ps

`include "bch_defines.svh"

module bch_locator_solver import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_t s1,
	input gf_t s3,
	output gf_t sigma1,
	output gf_t sigma2,
	output err_count_t count,
	output logic solve_done
);

	solver_state_e state;
	gf_t s1_q;
	gf_t s3_q;
	gf_t cube_q;
	gf_t sigma2_next;
	err_count_t count_next;

	// sigma2 = (S3 + S1^3) / S1, sigma1 is S1 itself
	assign sigma2_next = gf_mul(s3_q ^ cube_q, gf_inv(s1_q));

	always_comb begin
		if (s1_q == '0)
			count_next = (s3_q == '0) ? err_count_t'(0) : err_count_t'(`BCH_T + 1);
		else if (sigma2_next == '0)
			count_next = err_count_t'(1); // S3 equals S1 cubed
		else
			count_next = err_count_t'(`BCH_T);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= solver_idle;
			solve_done <= 1'b0;
		end else begin
			solve_done <= (state == solver_divide);
			case (state)
				solver_idle: if (start) state <= solver_cube;
				solver_cube: state <= solver_divide;
				solver_divide: state <= solver_hold;
				default: state <= solver_idle; // results stay put after the strobe
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == solver_idle && start) begin
			s1_q <= s1;
			s3_q <= s3;
		end
		if (state == solver_cube)
			cube_q <= gf_mul(gf_mul(s1_q, s1_q), s1_q);
		if (state == solver_divide) begin
			sigma1 <= s1_q;
			sigma2 <= sigma2_next; // zero when S1 is zero, so no roots are found
			count <= count_next;
		end
	end

endmodule

// ==== bch_chien_search.sv ====
`timescale 1ns/1ps

`include "bch_defines.svh"

module bch_chien_search import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_t sigma1,
	input gf_t sigma2,
	output logic loc_bit,
	output logic loc_first,
	output logic loc_valid
);

	localparam logic [3:0] last_pos = 4'(`BCH_N - 1);

	chien_state_e state;
	logic [3:0] pos;
	gf_t t1;
	gf_t t2;
	gf_t sum;

	// position i sits at x^(14-i), so the test point is alpha^(i+1)
	assign sum = gf_t'(1) ^ t1 ^ t2;

	assign loc_valid = (state == chien_scan);
	assign loc_first = loc_valid && (pos == '0);
	assign loc_bit = loc_valid && (sum == '0); // root of sigma, bit in error

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= chien_idle;
			pos <= '0;
		end else begin
			case (state)
				chien_idle: begin
					if (start) begin
						state <= chien_scan;
						pos <= '0;
					end
				end
				default: begin
					pos <= pos + 4'd1;
					if (pos == last_pos)
						state <= chien_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == chien_idle && start) begin
			t1 <= gf_mul(sigma1, gf_alpha);
			t2 <= gf_mul(sigma2, gf_alpha2);
		end else if (state == chien_scan) begin
			t1 <= gf_mul(t1, gf_alpha);
			t2 <= gf_mul(t2, gf_alpha2);
		end
	end

endmodule

// ==== bch_check_ring.sv ====
`timescale 1ns/1ps

`include "bch_defines.svh"

module bch_check_ring import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic push,
	input codeword_t error,
	input logic solve_done,
	input logic present,
	input err_count_t count,
	input logic loc_bit,
	input logic loc_valid,
	output logic wrong,
	output logic err_done,
	output codeword_t err_pattern,
	output err_count_t err_count
);

	localparam int depth = `BCH_RING_DEPTH;

	typedef logic [$clog2(depth)-1:0] ptr_t;

	codeword_t pattern_ring [depth];
	err_count_t count_ring [depth];
	logic [depth-1:0] present_ring;

	ptr_t wr_ptr;
	ptr_t present_rd;
	ptr_t count_rd;
	ptr_t pattern_rd;
	ptr_t wr_next;
	logic last_valid;
	logic overflow;
	logic present_bad;
	logic count_bad;
	logic pattern_bad;

	// weight of an injected pattern, saturating at the uncorrectable code
	function automatic err_count_t weight(input codeword_t w);
		int n;
		n = 0;
		for (int i = 0; i < `BCH_N; i++)
			n = n + int'(w[i]);
		return (n > `BCH_T) ? err_count_t'(`BCH_T + 1) : err_count_t'(n);
	endfunction

	function automatic ptr_t step(input ptr_t p);
		return (p == ptr_t'(depth - 1)) ? '0 : p + ptr_t'(1);
	endfunction

	assign wr_next = step(wr_ptr);
	assign err_done = last_valid && !loc_valid; // falling edge of the scan

	// ***************************************************************************
	// compares against the oldest entry of each stage
	// ***************************************************************************

	assign overflow = push && (wr_next == present_rd || wr_next == count_rd ||
		wr_next == pattern_rd);
	assign present_bad = solve_done && (present != present_ring[present_rd]);
	assign count_bad = solve_done && (count != count_ring[count_rd]);
	assign pattern_bad = err_done && (err_pattern != pattern_ring[pattern_rd]);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			present_rd <= '0;
			count_rd <= '0;
			pattern_rd <= '0;
			last_valid <= 1'b0;
			wrong <= 1'b0;
		end else begin
			last_valid <= loc_valid;
			if (push)
				wr_ptr <= wr_next;
			if (solve_done) begin
				present_rd <= step(present_rd);
				count_rd <= step(count_rd);
			end
			if (err_done)
				pattern_rd <= step(pattern_rd);
			if (overflow || present_bad || count_bad || pattern_bad)
				wrong <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pattern_ring[wr_ptr] <= error;
			count_ring[wr_ptr] <= weight(error);
			present_ring[wr_ptr] <= |error;
		end
		if (solve_done)
			err_count <= count;
		if (loc_valid)
			err_pattern <= {loc_bit, err_pattern[`BCH_N-1:1]}; // position 0 lands in bit 0
	end

endmodule

// ==== bch_loopback_top.sv ====
`timescale 1ns/1ps

module bch_loopback_top import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input message_t data_in,
	input codeword_t error,
	input logic encode_start,
	output logic busy,
	output logic wrong,
	output logic err_done,
	output codeword_t err_pattern,
	output err_count_t err_count
);

	logic accept;
	codeword_t flip_sr;
	logic enc_bit;
	logic enc_first;
	logic rx_bit;
	gf_t s1;
	gf_t s3;
	logic syn_done;
	gf_t sigma1;
	gf_t sigma2;
	err_count_t count;
	logic solve_done;
	logic loc_bit;
	logic loc_valid;

	assign accept = encode_start && !busy; // starts during a word are dropped

	// error pattern lines up with the encoder one bit per cycle
	always_ff @(posedge clk) begin
		flip_sr <= accept ? error : flip_sr >> 1;
	end

	assign rx_bit = enc_bit ^ flip_sr[0];

	bch_encoder u_encoder (
		.clk(clk), .reset(reset), .start(accept), .message(data_in),
		.out_bit(enc_bit), .out_first(enc_first), .busy(busy)
	);

	bch_syndrome u_syndrome (
		.clk(clk), .reset(reset), .start(enc_first), .in_bit(rx_bit),
		.s1(s1), .s3(s3), .syn_done(syn_done)
	);

	bch_locator_solver u_solver (
		.clk(clk), .reset(reset), .start(syn_done), .s1(s1), .s3(s3),
		.sigma1(sigma1), .sigma2(sigma2), .count(count), .solve_done(solve_done)
	);

	bch_chien_search u_chien (
		.clk(clk), .reset(reset), .start(solve_done), .sigma1(sigma1), .sigma2(sigma2),
		.loc_bit(loc_bit), .loc_first(), .loc_valid(loc_valid)
	);

	bch_check_ring u_check (
		.clk(clk), .reset(reset), .push(accept), .error(error),
		.solve_done(solve_done), .present(count != '0), .count(count),
		.loc_bit(loc_bit), .loc_valid(loc_valid), .wrong(wrong), .err_done(err_done),
		.err_pattern(err_pattern), .err_count(err_count)
	);

endmodule

// ==== bch_loopback_checks.svh ====
`ifndef BCH_LOOPBACK_CHECKS_SVH
`define BCH_LOOPBACK_CHECKS_SVH

// ***************************************************************************
// compare tasks, one per kind of DUT result
// ***************************************************************************

task automatic check_pattern(input string name, input codeword_t got, input codeword_t exp);
	if (got !== exp)
		stop_with_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_count(input string name, input err_count_t got, input err_count_t exp);
	if (got !== exp)
		stop_with_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
		stop_with_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_total(input string name, input int got, input int exp);
	if (got != exp)
		stop_with_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
endtask

// ***************************************************************************
// expected error patterns
// ***************************************************************************

function automatic codeword_t single_error(input int pos);
	return codeword_t'(1) << pos; // bit pos is flipped on the wire
endfunction

// second position is offset from the first so the two never coincide
function automatic codeword_t double_error();
	int a;
	int b;
	a = $urandom_range(`BCH_N - 1);
	b = (a + 1 + $urandom_range(`BCH_N - 2)) % `BCH_N;
	return single_error(a) | single_error(b);
endfunction

`endif

// ==== bch_loopback_tb.sv ====
`timescale 1ns/1ps

`include "bch_defines.svh"

module bch_loopback_tb import bch_pkg::*; ();

	localparam int num_clean = 8;
	localparam int num_entries = num_clean + `BCH_N + 12;
	localparam int timeout_cycles = (num_entries + 4) * 60;
	localparam int drive_delay = 2;

	typedef struct packed {
		message_t msg;
		codeword_t err;
		err_count_t exp_count;
		logic [2:0] gap; // idle cycles after busy falls
		logic poke; // extra encode_start while the word is in flight
	} entry_t;

	typedef struct packed {
		codeword_t pattern;
		err_count_t count;
	} result_t;

	logic clk;
	logic reset;
	message_t data_in;
	codeword_t error;
	logic encode_start;
	logic busy;
	logic wrong;
	logic err_done;
	codeword_t err_pattern;
	err_count_t err_count;

	entry_t stim [num_entries];
	result_t expected_q [$];
	result_t head;
	int accepted;
	int done_count;
	int busy_run;
	int cycle_count;

	bch_loopback_top u_bch_loopback_top (
		.clk(clk), .reset(reset), .data_in(data_in), .error(error),
		.encode_start(encode_start), .busy(busy), .wrong(wrong), .err_done(err_done),
		.err_pattern(err_pattern), .err_count(err_count)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	`include "bch_loopback_checks.svh"

	always #20 clk = ~clk;

	// clean words first, then every single error position, then random pairs
	task automatic build_table();
		for (int i = 0; i < num_entries; i++) begin
			if (i < num_clean)
				stim[i].msg = (i == 0) ? '0 : (i == 1) ? '1 : message_t'($urandom);
			else
				stim[i].msg = stim[i % num_clean].msg; // every message also goes out clean
			stim[i].gap = ($urandom_range(3) == 0) ? 3'($urandom_range(5)) : 3'd0;
			stim[i].poke = (i % 3 == 1);
			if (i < num_clean) begin
				stim[i].err = '0;
				stim[i].exp_count = err_count_t'(0);
			end else if (i < num_clean + `BCH_N) begin
				stim[i].err = single_error(i - num_clean);
				stim[i].exp_count = err_count_t'(1);
			end else begin
				stim[i].err = double_error();
				stim[i].exp_count = err_count_t'(2);
			end
		end
	endtask

	// ***************************************************************************
	// one word through the loopback
	// ***************************************************************************

	task automatic send_word(input entry_t e);
		result_t r;
		while (busy) begin
			@(posedge clk);
			#drive_delay;
		end
		data_in = e.msg;
		error = e.err;
		encode_start = 1'b1;
		r.pattern = e.err;
		r.count = e.exp_count;
		expected_q.push_back(r);
		accepted++;
		@(posedge clk);
		#drive_delay;
		encode_start = 1'b0;
		check_flag("busy", busy, 1'b1);
		if (e.poke) begin
			@(posedge clk);
			#drive_delay;
			data_in = ~e.msg; // must be dropped since busy is high
			error = ~e.err;
			encode_start = 1'b1;
			@(posedge clk);
			#drive_delay;
			encode_start = 1'b0;
		end
		while (busy) begin
			@(posedge clk);
			#drive_delay;
		end
		repeat (e.gap) begin
			@(posedge clk);
			#drive_delay;
		end
	endtask

	// outputs are sampled mid cycle away from the clock edge
	always @(negedge clk) begin
		if (!reset) begin
			check_flag("wrong", wrong, 1'b0);
			if (busy) begin
				busy_run++;
			end else if (busy_run != 0) begin
				check_total("busy cycles", busy_run, `BCH_N);
				busy_run = 0;
			end
			if (err_done) begin
				if (expected_q.size() == 0) begin
					stop_with_failure("err_done pulsed with no codeword outstanding");
				end else begin
					head = expected_q.pop_front();
					check_pattern("err_pattern", err_pattern, head.pattern);
					check_count("err_count", err_count, head.count);
					done_count++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
			stop_with_failure($sformatf("timeout after %0d cycles with results still missing",
				timeout_cycles));
	end

	initial begin
		void'($urandom(85671));
		clk = 1'b0;
		reset = 1'b1;
		data_in = '0;
		error = '0;
		encode_start = 1'b0;
		accepted = 0;
		done_count = 0;
		busy_run = 0;
		cycle_count = 0;
		build_table();
		repeat (5) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		foreach (stim[i])
			send_word(stim[i]);
		while (done_count != accepted) // one err_done for every accepted start
			@(posedge clk);
		repeat (40) @(posedge clk); // a stray err_done would show up in here
		#drive_delay;
		if (wrong === 1'b0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			check_flag("wrong", wrong, 1'b0);
		end
	end

endmodule

// ==== files.f ====
+incdir+.
bch_pkg.sv
bch_encoder.sv
bch_syndrome.sv
bch_locator_solver.sv
bch_chien_search.sv
bch_check_ring.sv
bch_loopback_top.sv
bch_loopback_tb.sv
